// ==== robot_ctrl.f ====
+incdir+include
rtl/robot_ctrl_pkg.sv
rtl/ir_nec_decoder.sv
rtl/target_finder.sv
rtl/drive_fsm.sv
rtl/motor_pwm.sv
rtl/robot_ctrl_top.sv
testbench/tb_robot_ctrl.sv

// ==== Makefile ====
TOP = tb_robot_ctrl

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f robot_ctrl.f --top-module $(TOP)

sim:
	verilator --binary --timing -f robot_ctrl.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir

// ==== testbench/tb_robot_ctrl.sv ====
`timescale 1ns/10ps
`include "robot_ctrl_settings.svh"

module tb_robot_ctrl;

  localparam int frame_w    = 12;
  localparam int frame_h    = 4;
  // clocks per NEC unit in the shrunk decoder
  localparam int nec_div    = 4;
  localparam int pwm_period = 1 << `PWM_BITS;

  logic                    clk_50;
  logic                    arst_n;
  logic                    irda_rxd;
  robot_ctrl_pkg::pixel_t  pixel;
  logic                    left_pwm;
  logic                    right_pwm;
  robot_ctrl_pkg::drive_t  drive;
  robot_ctrl_pkg::target_t target;

  int          errors      = 0;
  int          reports     = 0;
  int          frames_sent = 0;
  logic [31:0] rng         = 32'd75;
  // expected drive after every accepted event
  robot_ctrl_pkg::drive_t model_drive = '{mode: robot_ctrl_pkg::mode_idle,
                                          cmd: robot_ctrl_pkg::cmd_halt, speed: 2'd1};
  robot_ctrl_pkg::direction_e exp_dirs[$];
  robot_ctrl_pkg::drive_t     exp_drives[$];
  logic                       eof_d     = 1'b0;
  logic                       drive_due = 1'b0;
  robot_ctrl_pkg::direction_e dir_exp;
  robot_ctrl_pkg::drive_t     drive_exp;

  robot_ctrl_top #(
    .frame_w    (frame_w),
    .ir_tick_div(nec_div)
  ) i_robot_ctrl_top (
    .clk_50   (clk_50),
    .arst_n   (arst_n),
    .irda_rxd (irda_rxd),
    .pixel    (pixel),
    .left_pwm (left_pwm),
    .right_pwm(right_pwm),
    .drive    (drive),
    .target   (target)
  );

  always #2 clk_50 = ~clk_50;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic orange_ref(input robot_ctrl_pkg::color_t r,
                                      input robot_ctrl_pkg::color_t g,
                                      input robot_ctrl_pkg::color_t b);
    return (r >= `ORANGE_R_MIN) && (g >= `ORANGE_G_MIN) && (g <= `ORANGE_G_MAX) &&
           (b <= `ORANGE_B_MAX);
  endfunction

  // largest region wins with center then left on a tie
  function automatic robot_ctrl_pkg::direction_e ref_direction(input int cl, input int cc,
                                                               input int cr);
    if (cl + cc + cr < `TARGET_MIN_PIXELS) begin
      return robot_ctrl_pkg::dir_none;
    end
    if (cc >= cl && cc >= cr) begin
      return robot_ctrl_pkg::dir_center;
    end
    return (cl >= cr) ? robot_ctrl_pkg::dir_left : robot_ctrl_pkg::dir_right;
  endfunction

  function automatic robot_ctrl_pkg::drive_t ref_drive(
    input robot_ctrl_pkg::drive_t cur, input logic ir_valid, input robot_ctrl_pkg::ir_code_t code,
    input logic tgt_valid, input robot_ctrl_pkg::direction_e dir);
    robot_ctrl_pkg::drive_t nxt;
    nxt = cur;
    if (ir_valid) begin
      if (code == `BTN_STOP) begin
        nxt.mode = robot_ctrl_pkg::mode_idle;
        nxt.cmd  = robot_ctrl_pkg::cmd_halt;
      end else if (code == `BTN_AUTO) begin
        // auto starts standing still
        nxt.mode = robot_ctrl_pkg::mode_auto;
        nxt.cmd  = robot_ctrl_pkg::cmd_halt;
      end else if (code == `BTN_FWD || code == `BTN_LEFT || code == `BTN_RIGHT) begin
        nxt.mode = robot_ctrl_pkg::mode_manual;
        nxt.cmd  = (code == `BTN_FWD) ? robot_ctrl_pkg::cmd_forward :
                   (code == `BTN_LEFT) ? robot_ctrl_pkg::cmd_left : robot_ctrl_pkg::cmd_right;
      end else if (code == `BTN_SPEED1) begin
        nxt.speed = 2'd1;
      end else if (code == `BTN_SPEED2) begin
        nxt.speed = 2'd2;
      end else if (code == `BTN_SPEED3) begin
        nxt.speed = 2'd3;
      end
    end else if (tgt_valid && cur.mode == robot_ctrl_pkg::mode_auto) begin
      if (dir == robot_ctrl_pkg::dir_center) begin
        nxt.cmd = robot_ctrl_pkg::cmd_forward;
      end else if (dir == robot_ctrl_pkg::dir_left) begin
        nxt.cmd = robot_ctrl_pkg::cmd_left;
      end else if (dir == robot_ctrl_pkg::dir_right) begin
        nxt.cmd = robot_ctrl_pkg::cmd_right;
      end else begin
        nxt.cmd = robot_ctrl_pkg::cmd_halt;
      end
    end
    return nxt;
  endfunction

  function automatic int ref_duty(input robot_ctrl_pkg::speed_t speed);
    return int'(speed) * 64;
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
      errors++;
    end
  endtask

  // line level for a number of NEC units
  task automatic hold_rxd(input logic level, input int units);
    repeat (units * nec_div) begin
      @(posedge clk_50);
      #1;
      irda_rxd = level;
    end
  endtask

  task automatic send_nec(input robot_ctrl_pkg::ir_code_t code, input logic corrupt);
    logic [31:0] frame;
    // address 00 and its inverse then command and its inverse sent lsb first
    frame = {~code ^ (corrupt ? 8'h01 : 8'h00), code, 8'hFF, 8'h00};
    hold_rxd(1'b0, 16);
    hold_rxd(1'b1, 8);
    for (int i = 0; i < 32; i++) begin
      hold_rxd(1'b0, 1);
      hold_rxd(1'b1, frame[i] ? 3 : 1);
    end
    // closing burst then idle gap
    hold_rxd(1'b0, 1);
    hold_rxd(1'b1, 4);
  endtask

  task automatic wait_drive(input robot_ctrl_pkg::drive_t expected, input string name);
    int n;
    n = 0;
    while (drive !== expected && n < 2000) begin
      @(posedge clk_50);
      #1;
      n++;
    end
    if (drive !== expected) begin
      $display("timeout in %s: drive never reached the expected value", name);
      errors++;
    end
  endtask

  task automatic press(input robot_ctrl_pkg::ir_code_t code, input logic corrupt,
                       input string name);
    if (!corrupt) begin
      model_drive = ref_drive(model_drive, 1'b1, code, 1'b0, robot_ctrl_pkg::dir_none);
    end
    send_nec(code, corrupt);
    wait_drive(model_drive, name);
    check(name, 32'(model_drive), 32'(drive));
  endtask

  // random pixels with given rows of each region forced orange
  task automatic send_frame(input int rows_l, input int rows_c, input int rows_r);
    int                         cl;
    int                         cc;
    int                         cr;
    logic                       force_px;
    robot_ctrl_pkg::pixel_t     px;
    robot_ctrl_pkg::direction_e dir;
    cl = 0;
    cc = 0;
    cr = 0;
    for (int row = 0; row < frame_h; row++) begin
      for (int col = 0; col < frame_w; col++) begin
        rng      = xorshift32(rng);
        px.valid = 1'b1;
        px.sol   = (col == 0);
        px.eof   = (row == frame_h - 1 && col == frame_w - 1);
        px.r     = rng[7:0];
        px.g     = rng[15:8];
        px.b     = rng[23:16];
        if (col < frame_w / 3) begin
          force_px = (row < rows_l);
        end else if (col < 2 * frame_w / 3) begin
          force_px = (row < rows_c);
        end else begin
          force_px = (row < rows_r);
        end
        if (force_px) begin
          px.r = 8'd200;
          px.g = 8'd100;
          px.b = 8'd50;
        end
        if (orange_ref(px.r, px.g, px.b)) begin
          if (col < frame_w / 3) begin
            cl++;
          end else if (col < 2 * frame_w / 3) begin
            cc++;
          end else begin
            cr++;
          end
        end
        @(posedge clk_50);
        #1;
        pixel = px;
      end
    end
    dir         = ref_direction(cl, cc, cr);
    model_drive = ref_drive(model_drive, 1'b0, 8'h00, 1'b1, dir);
    exp_dirs.push_back(dir);
    exp_drives.push_back(model_drive);
    frames_sent++;
  endtask

  task automatic idle_pixels();
    @(posedge clk_50);
    #1;
    pixel = '0;
  endtask

  task automatic wait_reports();
    int n;
    n = 0;
    while ((reports < frames_sent || drive_due) && n < 500) begin
      @(posedge clk_50);
      #1;
      n++;
    end
    if (reports < frames_sent || drive_due) begin
      $display("timeout: only %0d of %0d target reports arrived", reports, frames_sent);
      errors++;
    end
  endtask

  // left wheel on forward and right turns and right wheel on forward and left turns
  task automatic measure_pwm(input string name);
    int hl;
    int hr;
    int exp_l;
    int exp_r;
    exp_l = (model_drive.cmd == robot_ctrl_pkg::cmd_forward ||
             model_drive.cmd == robot_ctrl_pkg::cmd_right) ? ref_duty(model_drive.speed) : 0;
    exp_r = (model_drive.cmd == robot_ctrl_pkg::cmd_forward ||
             model_drive.cmd == robot_ctrl_pkg::cmd_left) ? ref_duty(model_drive.speed) : 0;
    hl    = 0;
    hr    = 0;
    // new duty is latched by the next wrap
    repeat (pwm_period) @(posedge clk_50);
    #1;
    repeat (pwm_period) begin
      if (left_pwm) begin
        hl++;
      end
      if (right_pwm) begin
        hr++;
      end
      @(posedge clk_50);
      #1;
    end
    check({name, " left"}, exp_l, hl);
    check({name, " right"}, exp_r, hr);
  endtask

  // target report one cycle after eof and drive one cycle later
  always @(negedge clk_50) begin
    if (arst_n) begin
      if (drive_due) begin
        check("target drive", 32'(drive_exp), 32'(drive));
      end
      drive_due = 1'b0;
      if (eof_d) begin
        if (exp_dirs.size() == 0) begin
          $display("target report with no expected direction queued");
          errors++;
        end else begin
          dir_exp   = exp_dirs.pop_front();
          drive_exp = exp_drives.pop_front();
          check("target valid", 32'd1, 32'(target.valid));
          check("target direction", 32'(dir_exp), 32'(target.direction));
          drive_due = 1'b1;
          reports++;
        end
      end else if (target.valid) begin
        $display("target report with no frame end one cycle before");
        errors++;
      end
      eof_d = pixel.valid & pixel.eof;
    end
  end

  initial begin
    clk_50   = 1'b0;
    arst_n   = 1'b0;
    irda_rxd = 1'b1;
    pixel    = '0;
    repeat (4) @(posedge clk_50);
    #1;
    arst_n = 1'b1;
    check("reset drive", 32'(model_drive), 32'(drive));
    check("reset target valid", 32'd0, 32'(target.valid));
    measure_pwm("reset pwm");
    // remote buttons
    press(`BTN_FWD, 1'b0, "nec forward");
    press(`BTN_LEFT, 1'b0, "nec left");
    press(`BTN_RIGHT, 1'b0, "nec right");
    press(`BTN_SPEED2, 1'b0, "nec speed2");
    press(`BTN_SPEED3, 1'b0, "nec speed3");
    press(`BTN_SPEED1, 1'b0, "nec speed1");
    press(`BTN_FWD, 1'b1, "nec corrupted inverse");
    press(8'h55, 1'b0, "nec unknown code");
    press(`BTN_STOP, 1'b0, "nec stop");
    // auto tracking with frames back to back
    press(`BTN_AUTO, 1'b0, "nec auto");
    send_frame(0, 0, 0);
    send_frame(4, 0, 0);
    send_frame(0, 3, 0);
    send_frame(0, 0, 2);
    send_frame(2, 2, 0);
    send_frame(1, 0, 1);
    send_frame(1, 0, 0);
    send_frame(0, 4, 4);
    send_frame(3, 1, 3);
    idle_pixels();
    wait_reports();
    // manual mode ignores the camera
    press(`BTN_FWD, 1'b0, "nec manual forward");
    send_frame(0, 0, 4);
    send_frame(4, 0, 0);
    idle_pixels();
    wait_reports();
    // duty per speed and command
    press(`BTN_SPEED1, 1'b0, "pwm speed1");
    press(`BTN_FWD, 1'b0, "pwm s1 forward");
    measure_pwm("pwm s1 forward");
    press(`BTN_LEFT, 1'b0, "pwm s1 left");
    measure_pwm("pwm s1 left");
    press(`BTN_RIGHT, 1'b0, "pwm s1 right");
    measure_pwm("pwm s1 right");
    press(`BTN_STOP, 1'b0, "pwm s1 stop");
    measure_pwm("pwm s1 stop");
    press(`BTN_SPEED2, 1'b0, "pwm speed2");
    press(`BTN_FWD, 1'b0, "pwm s2 forward");
    measure_pwm("pwm s2 forward");
    press(`BTN_LEFT, 1'b0, "pwm s2 left");
    measure_pwm("pwm s2 left");
    press(`BTN_STOP, 1'b0, "pwm s2 stop");
    measure_pwm("pwm s2 stop");
    press(`BTN_RIGHT, 1'b0, "pwm s2 right");
    measure_pwm("pwm s2 right");
    press(`BTN_SPEED3, 1'b0, "pwm speed3");
    measure_pwm("pwm s3 right");
    press(`BTN_FWD, 1'b0, "pwm s3 forward");
    measure_pwm("pwm s3 forward");
    press(`BTN_LEFT, 1'b0, "pwm s3 left");
    measure_pwm("pwm s3 left");
    press(`BTN_STOP, 1'b0, "pwm s3 stop");
    measure_pwm("pwm s3 stop");
    $display("summary: %0d errors, %0d target reports checked", errors, reports);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== rtl/robot_ctrl_top.sv ====
`timescale 1ns/10ps
`include "robot_ctrl_settings.svh"

module robot_ctrl_top #(
  parameter int frame_w     = 640,
  parameter int ir_tick_div = `IR_TICK_DIV_DEFAULT
) (
  input  logic                    clk_50,
  input  logic                    arst_n,
  input  logic                    irda_rxd,
  input  robot_ctrl_pkg::pixel_t  pixel,
  output logic                    left_pwm,
  output logic                    right_pwm,
  output robot_ctrl_pkg::drive_t  drive,
  output robot_ctrl_pkg::target_t target
);

  // remote button pulses into the FSM
  robot_ctrl_pkg::ir_event_t ir_event;

  ir_nec_decoder #(
    .tick_div(ir_tick_div)
  ) u_ir_nec_decoder (
    .clk_50  (clk_50),
    .arst_n  (arst_n),
    .irda_rxd(irda_rxd),
    .ir_event(ir_event)
  );

  target_finder #(
    .frame_w(frame_w)
  ) u_target_finder (
    .clk_50(clk_50),
    .arst_n(arst_n),
    .pixel (pixel),
    .target(target)
  );

  drive_fsm u_drive_fsm (
    .clk_50  (clk_50),
    .arst_n  (arst_n),
    .ir_event(ir_event),
    .target  (target),
    .drive   (drive)
  );

  motor_pwm u_motor_pwm (
    .clk_50   (clk_50),
    .arst_n   (arst_n),
    .drive    (drive),
    .left_pwm (left_pwm),
    .right_pwm(right_pwm)
  );

endmodule

// ==== rtl/motor_pwm.sv ====
`timescale 1ns/10ps
`include "robot_ctrl_settings.svh"

module motor_pwm (
  input  logic                   clk_50,
  input  logic                   arst_n,
  input  robot_ctrl_pkg::drive_t drive,
  output logic                   left_pwm,
  output logic                   right_pwm
);

  logic [`PWM_BITS-1:0] pwm_cnt;
  logic [`PWM_BITS-1:0] duty;
  logic                 run_left;
  logic                 run_right;
  logic [`PWM_BITS-1:0] duty_left_q;
  logic [`PWM_BITS-1:0] duty_right_q;

  // speed in quarters of the period
  assign duty = {drive.speed, {(`PWM_BITS - 2){1'b0}}};

  // a turn stops the inner wheel, idle stops both
  assign run_left  = (drive.mode != robot_ctrl_pkg::mode_idle) &&
                     (drive.cmd == robot_ctrl_pkg::cmd_forward ||
                      drive.cmd == robot_ctrl_pkg::cmd_right);
  assign run_right = (drive.mode != robot_ctrl_pkg::mode_idle) &&
                     (drive.cmd == robot_ctrl_pkg::cmd_forward ||
                      drive.cmd == robot_ctrl_pkg::cmd_left);

  always_ff @(posedge clk_50 or negedge arst_n) begin
    if (!arst_n) begin
      pwm_cnt      <= '0;
      duty_left_q  <= '0;
      duty_right_q <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
      // new duty from count 0 on
      if (&pwm_cnt) begin
        duty_left_q  <= run_left ? duty : '0;
        duty_right_q <= run_right ? duty : '0;
      end
    end
  end

  assign left_pwm  = (pwm_cnt < duty_left_q);
  assign right_pwm = (pwm_cnt < duty_right_q);

endmodule

// ==== rtl/drive_fsm.sv ====
`timescale 1ns/10ps
`include "robot_ctrl_settings.svh"

module drive_fsm (
  input  logic                      clk_50,
  input  logic                      arst_n,
  input  robot_ctrl_pkg::ir_event_t ir_event,
  input  robot_ctrl_pkg::target_t   target,
  output robot_ctrl_pkg::drive_t    drive
);

  robot_ctrl_pkg::drive_mode_e mode_q;
  robot_ctrl_pkg::drive_cmd_e  cmd_q;
  robot_ctrl_pkg::speed_t      speed_q;

  always_ff @(posedge clk_50 or negedge arst_n) begin
    if (!arst_n) begin
      mode_q  <= robot_ctrl_pkg::mode_idle;
      cmd_q   <= robot_ctrl_pkg::cmd_halt;
      speed_q <= 2'd1;
    end else if (ir_event.valid) begin
      // remote has priority over the camera
      case (ir_event.code)
        `BTN_STOP: begin
          mode_q <= robot_ctrl_pkg::mode_idle;
          cmd_q  <= robot_ctrl_pkg::cmd_halt;
        end
        `BTN_AUTO: begin
          // stand still until the first target report
          mode_q <= robot_ctrl_pkg::mode_auto;
          cmd_q  <= robot_ctrl_pkg::cmd_halt;
        end
        `BTN_FWD: begin
          mode_q <= robot_ctrl_pkg::mode_manual;
          cmd_q  <= robot_ctrl_pkg::cmd_forward;
        end
        `BTN_LEFT: begin
          mode_q <= robot_ctrl_pkg::mode_manual;
          cmd_q  <= robot_ctrl_pkg::cmd_left;
        end
        `BTN_RIGHT: begin
          mode_q <= robot_ctrl_pkg::mode_manual;
          cmd_q  <= robot_ctrl_pkg::cmd_right;
        end
        // speed keys leave mode and command alone
        `BTN_SPEED1: speed_q <= 2'd1;
        `BTN_SPEED2: speed_q <= 2'd2;
        `BTN_SPEED3: speed_q <= 2'd3;
        default: begin
          // unknown key, nothing
        end
      endcase
    end else if (target.valid && mode_q == robot_ctrl_pkg::mode_auto) begin
      // steer toward the target
      case (target.direction)
        robot_ctrl_pkg::dir_center: cmd_q <= robot_ctrl_pkg::cmd_forward;
        robot_ctrl_pkg::dir_left:   cmd_q <= robot_ctrl_pkg::cmd_left;
        robot_ctrl_pkg::dir_right:  cmd_q <= robot_ctrl_pkg::cmd_right;
        // lost it, stop
        default:                    cmd_q <= robot_ctrl_pkg::cmd_halt;
      endcase
    end
  end

  assign drive = '{mode: mode_q, cmd: cmd_q, speed: speed_q};

endmodule

// ==== rtl/target_finder.sv ====
`timescale 1ns/10ps
`include "robot_ctrl_settings.svh"

module target_finder #(
  parameter int frame_w = 640
) (
  input  logic                    clk_50,
  input  logic                    arst_n,
  input  robot_ctrl_pkg::pixel_t  pixel,
  output robot_ctrl_pkg::target_t target
);

  // region boundaries in columns
  localparam int left_end   = frame_w / 3;
  localparam int center_end = 2 * frame_w / 3;

  robot_ctrl_pkg::col_t       col_q;
  robot_ctrl_pkg::col_t       col;
  logic                       is_orange;
  logic                       in_left;
  logic                       in_center;
  logic                       hit_left;
  logic                       hit_center;
  logic                       hit_right;
  robot_ctrl_pkg::count_t     cnt_left;
  robot_ctrl_pkg::count_t     cnt_center;
  robot_ctrl_pkg::count_t     cnt_right;
  robot_ctrl_pkg::count_t     sum_left;
  robot_ctrl_pkg::count_t     sum_center;
  robot_ctrl_pkg::count_t     sum_right;
  logic [19:0]                total;
  logic                       frame_end;
  robot_ctrl_pkg::direction_e dir_next;
  robot_ctrl_pkg::direction_e dir_q;
  logic                       valid_q;

  // sol pixel is column 0
  assign col = pixel.sol ? '0 : col_q;

  always_ff @(posedge clk_50 or negedge arst_n) begin
    if (!arst_n) begin
      col_q <= '0;
    end else if (pixel.valid) begin
      col_q <= col + 1'b1;
    end
  end

  assign is_orange = (pixel.r >= `ORANGE_R_MIN) &&
                     (pixel.g >= `ORANGE_G_MIN) && (pixel.g <= `ORANGE_G_MAX) &&
                     (pixel.b <= `ORANGE_B_MAX);

  assign in_left    = (col < robot_ctrl_pkg::col_t'(left_end));
  assign in_center  = (col < robot_ctrl_pkg::col_t'(center_end));
  assign hit_left   = pixel.valid & is_orange & in_left;
  assign hit_center = pixel.valid & is_orange & ~in_left & in_center;
  assign hit_right  = pixel.valid & is_orange & ~in_center;

  // counts including the current pixel
  assign sum_left   = cnt_left + robot_ctrl_pkg::count_t'(hit_left);
  assign sum_center = cnt_center + robot_ctrl_pkg::count_t'(hit_center);
  assign sum_right  = cnt_right + robot_ctrl_pkg::count_t'(hit_right);
  // wider than one count, a full frame can pass 18 bits
  assign total      = 20'(sum_left) + 20'(sum_center) + 20'(sum_right);
  assign frame_end  = pixel.valid & pixel.eof;

  // center wins ties, then left
  always_comb begin
    if (total < 20'(`TARGET_MIN_PIXELS)) begin
      dir_next = robot_ctrl_pkg::dir_none;
    end else if (sum_center >= sum_left && sum_center >= sum_right) begin
      dir_next = robot_ctrl_pkg::dir_center;
    end else if (sum_left >= sum_right) begin
      dir_next = robot_ctrl_pkg::dir_left;
    end else begin
      dir_next = robot_ctrl_pkg::dir_right;
    end
  end

  always_ff @(posedge clk_50 or negedge arst_n) begin
    if (!arst_n) begin
      cnt_left   <= '0;
      cnt_center <= '0;
      cnt_right  <= '0;
      valid_q    <= 1'b0;
    end else begin
      valid_q <= frame_end;
      if (frame_end) begin
        // next frame may start right away
        cnt_left   <= '0;
        cnt_center <= '0;
        cnt_right  <= '0;
      end else begin
        cnt_left   <= sum_left;
        cnt_center <= sum_center;
        cnt_right  <= sum_right;
      end
    end
  end

  always_ff @(posedge clk_50) begin
    if (frame_end) begin
      dir_q <= dir_next;
    end
  end

  assign target = '{valid: valid_q, direction: dir_q};

endmodule

// ==== rtl/ir_nec_decoder.sv ====
`timescale 1ns/10ps
`include "robot_ctrl_settings.svh"

module ir_nec_decoder #(
  parameter int tick_div = `IR_TICK_DIV_DEFAULT
) (
  input  logic                      clk_50,
  input  logic                      arst_n,
  input  logic                      irda_rxd,
  output robot_ctrl_pkg::ir_event_t ir_event
);

  localparam int tick_w = $clog2(tick_div + 1);

  typedef enum logic [1:0] {
    st_idle,
    st_leader,
    st_bits,
    st_stop
  } nec_state_e;

  logic [1:0]               sync_q;
  logic                     rxd_d;
  logic                     rise;
  logic                     fall;
  logic [tick_w-1:0]        tick_cnt;
  logic                     tick;
  logic [4:0]               run_units;
  logic                     run_sat;
  nec_state_e               state;
  logic [4:0]               bit_cnt;
  logic [31:0]              shift_q;
  logic                     frame_ok;
  logic                     evt_valid_q;
  robot_ctrl_pkg::ir_code_t evt_code_q;

  // two-flop sync, receiver idles high
  always_ff @(posedge clk_50 or negedge arst_n) begin
    if (!arst_n) begin
      sync_q <= 2'b11;
      rxd_d  <= 1'b1;
    end else begin
      sync_q <= {sync_q[0], irda_rxd};
      rxd_d  <= sync_q[1];
    end
  end

  // rise ends a carrier burst, fall ends a space
  assign rise = sync_q[1] & ~rxd_d;
  assign fall = ~sync_q[1] & rxd_d;

  assign tick    = (tick_cnt == tick_w'(tick_div - 1));
  assign run_sat = &run_units;

  // run length in units, restarted on every edge
  always_ff @(posedge clk_50 or negedge arst_n) begin
    if (!arst_n) begin
      tick_cnt  <= '0;
      run_units <= '0;
    end else if (rise || fall) begin
      // edge cycle is already the first cycle of the new run
      tick_cnt  <= tick_w'(1);
      run_units <= '0;
    end else begin
      tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
      if (tick && !run_sat) begin
        run_units <= run_units + 1'b1;
      end
    end
  end

  // address vs inverse, command vs inverse
  assign frame_ok = (shift_q[7:0] == ~shift_q[15:8]) &&
                    (shift_q[23:16] == ~shift_q[31:24]);

  always_ff @(posedge clk_50 or negedge arst_n) begin
    if (!arst_n) begin
      state       <= st_idle;
      bit_cnt     <= '0;
      evt_valid_q <= 1'b0;
    end else begin
      evt_valid_q <= 1'b0;
      if (state != st_idle && run_sat) begin
        // run far too long, frame is broken
        state <= st_idle;
      end else begin
        case (state)
          st_idle: begin
            if (rise && run_units >= 5'(`NEC_LEADER_LOW_MIN)) begin
              state <= st_leader;
            end
          end
          st_leader: begin
            // short space here is a repeat code, dropped
            if (fall) begin
              bit_cnt <= '0;
              state   <= (run_units >= 5'(`NEC_LEADER_HIGH_MIN)) ? st_bits : st_idle;
            end
          end
          st_bits: begin
            if (fall) begin
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt == 5'd31) begin
                state <= st_stop;
              end
            end
          end
          default: begin
            // end of closing burst
            if (rise) begin
              evt_valid_q <= frame_ok;
              state       <= st_idle;
            end
          end
        endcase
      end
    end
  end

  // lsb first, bit value from the space length
  always_ff @(posedge clk_50) begin
    if (state == st_bits && fall) begin
      shift_q <= {(run_units >= 5'(`NEC_ONE_MIN)), shift_q[31:1]};
    end
    if (state == st_stop && rise) begin
      evt_code_q <= shift_q[23:16];
    end
  end

  assign ir_event = '{valid: evt_valid_q, code: evt_code_q};

endmodule

// ==== rtl/robot_ctrl_pkg.sv ====
package robot_ctrl_pkg;

  // widths with a meaning
  typedef logic [7:0]  color_t;
  typedef logic [9:0]  col_t;
  typedef logic [17:0] count_t;
  typedef logic [7:0]  ir_code_t;
  // speed level, 0 to 3
  typedef logic [1:0]  speed_t;

  typedef enum logic [1:0] {
    dir_none,
    dir_left,
    dir_center,
    dir_right
  } direction_e;

  typedef enum logic [1:0] {
    mode_idle,
    mode_manual,
    mode_auto
  } drive_mode_e;

  typedef enum logic [1:0] {
    cmd_halt,
    cmd_forward,
    cmd_left,
    cmd_right
  } drive_cmd_e;

  // one pixel per cycle while valid, no stall
  typedef struct packed {
    logic   valid;
    // first pixel of a line
    logic   sol;
    // last pixel of the frame
    logic   eof;
    color_t r;
    color_t g;
    color_t b;
  } pixel_t;

  // single-cycle pulse per accepted NEC frame
  typedef struct packed {
    logic     valid;
    ir_code_t code;
  } ir_event_t;

  // single-cycle pulse per frame
  typedef struct packed {
    logic       valid;
    direction_e direction;
  } target_t;

  typedef struct packed {
    drive_mode_e mode;
    drive_cmd_e  cmd;
    speed_t      speed;
  } drive_t;

endpackage

// ==== include/robot_ctrl_settings.svh ====
`ifndef ROBOT_CTRL_SETTINGS_SVH
`define ROBOT_CTRL_SETTINGS_SVH

// orange window on the 8-bit channels
`define ORANGE_R_MIN 8'd180
`define ORANGE_G_MIN 8'd60
`define ORANGE_G_MAX 8'd160
`define ORANGE_B_MAX 8'd90
// fewer orange pixels than this in a frame means no target
`define TARGET_MIN_PIXELS 6

// NEC command bytes of the remote
`define BTN_FWD    8'h1A
`define BTN_LEFT   8'h14
`define BTN_RIGHT  8'h18
`define BTN_STOP   8'h12
`define BTN_AUTO   8'h0F
`define BTN_SPEED1 8'h01
`define BTN_SPEED2 8'h02
`define BTN_SPEED3 8'h03

// minimum run lengths in NEC units of 562.5 us
`define NEC_LEADER_LOW_MIN  12
`define NEC_LEADER_HIGH_MIN 6
`define NEC_ONE_MIN         2

`define PWM_BITS 8
// 562.5 us at 50 MHz
`define IR_TICK_DIV_DEFAULT 28125

`endif
